//--- source/ctrl_pkg.sv
/*
 * Controller package
 * state, PC-select, jump-kind and forwarding-select encodings shared by
 * the controller blocks, plus the performance counter width
 */
package ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////
  // control FSM
  ////////////////////////////////////////////////////////////////////////

  // core control states, two-step flush at the end
  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH_EX,
    FLUSH_WB
  } ctrl_state_t;

  ////////////////////////////////////////////////////////////////////////
  // fetch and decode encodings
  ////////////////////////////////////////////////////////////////////////

  // fetch address source seen by the IF stage
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_mux_t;

  // control transfer kind of the instruction in decode
  typedef enum logic [1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_kind_t;

  // operand source in ID
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fwd_sel_t;

  // width of each event counter, wraps on overflow
  localparam int PERF_CNT_W = 16;

endpackage

//--- source/pipe_ctrl_fsm.sv
/*
 * Pipeline control FSM
 * sequences boot, sleep and decode, issues PC redirects for jumps,
 * branches, exceptions and eret, and runs the two-step pipeline flush
 */
module pipe_ctrl_fsm (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fetch_enable_i,
  input  logic                 instr_valid_i,
  input  logic                 branch_taken_ex_i,
  input  ctrl_pkg::jump_kind_t jump_in_dec_i,
  input  logic                 eret_insn_i,
  input  logic                 pipe_flush_i,
  input  logic                 exc_req_i,
  input  logic                 ext_req_i,
  input  logic                 id_ready_i,
  input  logic                 ex_valid_i,
  input  logic                 jr_stall_i,
  output logic                 instr_req_o,
  output logic                 ctrl_busy_o,
  output logic                 is_decoding_o,
  output logic                 pc_set_o,
  output ctrl_pkg::pc_mux_t    pc_mux_o,
  output logic                 exc_ack_o,
  output logic                 exc_save_if_o,
  output logic                 exc_save_id_o,
  output logic                 exc_save_takenbranch_o,
  output logic                 exc_restore_id_o,
  output logic                 halt_if_o,
  output logic                 halt_id_o
);
  import ctrl_pkg::*;

  ctrl_state_t ctrl_fsm_cs;
  ctrl_state_t ctrl_fsm_ns;

  // set once a jump or eret redirect went out for the instruction in ID
  logic jump_done_d;
  logic jump_done_q;

  ////////////////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    // fetch runs unless a state says otherwise
    instr_req_o            = 1'b1;
    ctrl_busy_o            = 1'b1;
    is_decoding_o          = 1'b0;
    pc_set_o               = 1'b0;
    pc_mux_o               = PC_BOOT;
    exc_ack_o              = 1'b0;
    exc_save_if_o          = 1'b0;
    exc_save_id_o          = 1'b0;
    exc_save_takenbranch_o = 1'b0;
    exc_restore_id_o       = 1'b0;
    halt_if_o              = 1'b0;
    halt_id_o              = 1'b0;
    jump_done_d            = jump_done_q;
    ctrl_fsm_ns            = ctrl_fsm_cs;

    case (ctrl_fsm_cs)
      // idle until fetch is enabled
      RESET:
      begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        if (fetch_enable_i)
          ctrl_fsm_ns = BOOT_SET;
      end

      // load the boot address into the fetch PC
      BOOT_SET:
      begin
        pc_set_o    = 1'b1;
        pc_mux_o    = PC_BOOT;
        ctrl_fsm_ns = FIRST_FETCH;
      end

      // wake on fetch enable or an interrupt
      SLEEP:
      begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || exc_req_i)
          ctrl_fsm_ns = FIRST_FETCH;
      end

      // wait for the first instruction to reach ID
      FIRST_FETCH:
      begin
        if (id_ready_i)
          ctrl_fsm_ns = DECODE;
        // pipeline is empty here, so the IF PC is the one to save
        if (exc_req_i)
        begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_EXCEPTION;
          exc_ack_o     = 1'b1;
          exc_save_if_o = 1'b1;
        end
      end

      DECODE:
      begin
        // only decode when no taken branch in EX kills the ID instruction
        if (instr_valid_i && !branch_taken_ex_i)
        begin
          is_decoding_o = 1'b1;

          // target is known in ID, redirect once the operand is ready
          if (jump_in_dec_i == BRANCH_JAL || jump_in_dec_i == BRANCH_JALR)
          begin
            pc_mux_o = PC_JUMP;
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end
          else if (exc_req_i)
          begin
            // keep the ID instruction out of EX, resume from it later
            pc_set_o      = 1'b1;
            pc_mux_o      = PC_EXCEPTION;
            exc_ack_o     = 1'b1;
            halt_id_o     = 1'b1;
            exc_save_id_o = 1'b1;
          end

          // exception return, one redirect per instruction
          if (eret_insn_i)
          begin
            pc_mux_o         = PC_ERET;
            exc_restore_id_o = 1'b1;
            if (!jump_done_q)
            begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end

          // WFI, or eret back into sleep
          if (pipe_flush_i || (eret_insn_i && !fetch_enable_i))
          begin
            halt_if_o   = 1'b1;
            halt_id_o   = 1'b1;
            ctrl_fsm_ns = FLUSH_EX;
          end
        end

        // external interrupt between instructions
        if (!instr_valid_i && !branch_taken_ex_i && ext_req_i)
        begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_EXCEPTION;
          exc_ack_o     = 1'b1;
          halt_id_o     = 1'b1;
          exc_save_if_o = 1'b1;
        end

        // taken branch in EX, the ID instruction is on the wrong path
        if (branch_taken_ex_i)
        begin
          pc_set_o = 1'b1;
          pc_mux_o = PC_BRANCH;
          // interrupt wins, the branch target is saved as return address
          if (ext_req_i)
          begin
            pc_mux_o               = PC_EXCEPTION;
            exc_ack_o              = 1'b1;
            halt_id_o              = 1'b1;
            exc_save_takenbranch_o = 1'b1;
          end
        end
      end

      // let the instruction in EX finish
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
          ctrl_fsm_ns = FLUSH_WB;
      end

      // WB drains in one cycle
      FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i)
        begin
          halt_if_o   = 1'b0;
          ctrl_fsm_ns = DECODE;
        end
        else
        begin
          ctrl_fsm_ns = SLEEP;
        end
      end

      default:
      begin
        instr_req_o = 1'b0;
        ctrl_fsm_ns = RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////
  // state registers
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ctrl_fsm_cs <= RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      ctrl_fsm_cs <= ctrl_fsm_ns;
      // a new instruction enters ID once ID accepts, so the flag clears
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

endmodule

//--- source/hazard_unit.sv
/*
 * Hazard unit
 * detects load-use and jump-register hazards in ID and decides when the
 * register write enable of the decoded instruction is dropped
 */
module hazard_unit (
  input  logic                 is_decoding_i,
  input  logic                 illegal_insn_i,
  input  ctrl_pkg::jump_kind_t jump_in_dec_i,
  input  logic                 data_req_ex_i,
  input  logic                 regfile_we_ex_i,
  input  logic                 regfile_we_wb_i,
  input  logic                 regfile_alu_we_fw_i,
  input  logic                 reg_d_ex_is_reg_a_i,
  input  logic                 reg_d_ex_is_reg_b_i,
  input  logic                 reg_d_wb_is_reg_a_i,
  input  logic                 reg_d_alu_is_reg_a_i,
  output logic                 load_stall_o,
  output logic                 jr_stall_o,
  output logic                 deassert_we_o
);
  import ctrl_pkg::*;

  logic ex_load_pending;
  logic ra_write_pending;

  // load in EX whose data is not back yet
  assign ex_load_pending = data_req_ex_i & regfile_we_ex_i;

  // any stage still has to write the register that JALR reads
  assign ra_write_pending = (regfile_we_wb_i & reg_d_wb_is_reg_a_i) |
                            (regfile_we_ex_i & reg_d_ex_is_reg_a_i) |
                            (regfile_alu_we_fw_i & reg_d_alu_is_reg_a_i);

  // load result cannot be forwarded in time
  assign load_stall_o = ex_load_pending & (reg_d_ex_is_reg_a_i | reg_d_ex_is_reg_b_i);

  // JALR target comes straight from the register file, no forwarding
  assign jr_stall_o = (jump_in_dec_i == BRANCH_JALR) & ra_write_pending;

  // the ID instruction must not write back while it is not really issued
  assign deassert_we_o = ~is_decoding_i | illegal_insn_i | load_stall_o | jr_stall_o;

endmodule

//--- source/operand_fwd_unit.sv
/*
 * Operand forwarding unit
 * picks the source of operands A and B in ID from the WB and ALU
 * write-back address matches
 */
module operand_fwd_unit (
  input  logic               regfile_we_wb_i,
  input  logic               regfile_alu_we_fw_i,
  input  logic               reg_d_wb_is_reg_a_i,
  input  logic               reg_d_wb_is_reg_b_i,
  input  logic               reg_d_alu_is_reg_a_i,
  input  logic               reg_d_alu_is_reg_b_i,
  output ctrl_pkg::fwd_sel_t operand_a_fw_mux_sel_o,
  output ctrl_pkg::fwd_sel_t operand_b_fw_mux_sel_o
);
  import ctrl_pkg::*;

  always_comb
  begin
    operand_a_fw_mux_sel_o = SEL_REGFILE;
    operand_b_fw_mux_sel_o = SEL_REGFILE;

    // WB to ID
    if (regfile_we_wb_i)
    begin
      if (reg_d_wb_is_reg_a_i)
        operand_a_fw_mux_sel_o = SEL_FW_WB;
      if (reg_d_wb_is_reg_b_i)
        operand_b_fw_mux_sel_o = SEL_FW_WB;
    end

    // EX to ID, younger result so it overrides WB
    if (regfile_alu_we_fw_i)
    begin
      if (reg_d_alu_is_reg_a_i)
        operand_a_fw_mux_sel_o = SEL_FW_EX;
      if (reg_d_alu_is_reg_b_i)
        operand_b_fw_mux_sel_o = SEL_FW_EX;
    end
  end

endmodule

//--- source/perf_counters.sv
/*
 * Performance counters
 * counts jump cycles, jump-register stall cycles and load stall cycles
 */
module perf_counters (
  input  logic                           clk,
  input  logic                           rst_n,
  input  ctrl_pkg::jump_kind_t           jump_in_id_i,
  input  logic                           jr_stall_i,
  input  logic                           load_stall_i,
  output logic [ctrl_pkg::PERF_CNT_W-1:0] jump_cnt_o,
  output logic [ctrl_pkg::PERF_CNT_W-1:0] jr_stall_cnt_o,
  output logic [ctrl_pkg::PERF_CNT_W-1:0] ld_stall_cnt_o
);
  import ctrl_pkg::*;

  logic                  jump_event;
  logic [PERF_CNT_W-1:0] jump_cnt_q;
  logic [PERF_CNT_W-1:0] jr_stall_cnt_q;
  logic [PERF_CNT_W-1:0] ld_stall_cnt_q;

  // unconditional jumps only, conditional branches are not counted
  assign jump_event = (jump_in_id_i == BRANCH_JAL) || (jump_in_id_i == BRANCH_JALR);

  ////////////////////////////////////////////////////////////////////////
  // counters
  ////////////////////////////////////////////////////////////////////////

  // plain wrap on overflow
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      jump_cnt_q     <= '0;
      jr_stall_cnt_q <= '0;
      ld_stall_cnt_q <= '0;
    end
    else
    begin
      if (jump_event)
        jump_cnt_q <= jump_cnt_q + PERF_CNT_W'(1);
      if (jr_stall_i)
        jr_stall_cnt_q <= jr_stall_cnt_q + PERF_CNT_W'(1);
      if (load_stall_i)
        ld_stall_cnt_q <= ld_stall_cnt_q + PERF_CNT_W'(1);
    end
  end

  assign jump_cnt_o     = jump_cnt_q;
  assign jr_stall_cnt_o = jr_stall_cnt_q;
  assign ld_stall_cnt_o = ld_stall_cnt_q;

endmodule

//--- source/core_controller.sv
/*
 * Core controller
 * main control of the in-order pipeline: FSM, hazard stalls, operand
 * forwarding select and event counters
 */
module core_controller (
  input  logic                            clk,
  input  logic                            rst_n,
  // fetch and decode
  input  logic                            fetch_enable_i,
  input  logic                            instr_valid_i,
  input  logic                            illegal_insn_i,
  input  logic                            eret_insn_i,
  input  logic                            pipe_flush_i,
  input  logic                            branch_taken_ex_i,
  input  ctrl_pkg::jump_kind_t            jump_in_dec_i,
  input  ctrl_pkg::jump_kind_t            jump_in_id_i,
  output logic                            instr_req_o,
  output logic                            ctrl_busy_o,
  output logic                            is_decoding_o,
  output logic                            pc_set_o,
  output ctrl_pkg::pc_mux_t               pc_mux_o,
  // exceptions
  input  logic                            exc_req_i,
  input  logic                            ext_req_i,
  output logic                            exc_ack_o,
  output logic                            exc_save_if_o,
  output logic                            exc_save_id_o,
  output logic                            exc_save_takenbranch_o,
  output logic                            exc_restore_id_o,
  // pipeline status
  input  logic                            id_ready_i,
  input  logic                            ex_valid_i,
  input  logic                            data_req_ex_i,
  // write-back ports and address matches
  input  logic                            regfile_we_ex_i,
  input  logic                            regfile_we_wb_i,
  input  logic                            regfile_alu_we_fw_i,
  input  logic                            reg_d_ex_is_reg_a_i,
  input  logic                            reg_d_ex_is_reg_b_i,
  input  logic                            reg_d_wb_is_reg_a_i,
  input  logic                            reg_d_wb_is_reg_b_i,
  input  logic                            reg_d_alu_is_reg_a_i,
  input  logic                            reg_d_alu_is_reg_b_i,
  // stalls and forwarding
  output logic                            halt_if_o,
  output logic                            halt_id_o,
  output logic                            deassert_we_o,
  output logic                            load_stall_o,
  output logic                            jr_stall_o,
  output ctrl_pkg::fwd_sel_t              operand_a_fw_mux_sel_o,
  output ctrl_pkg::fwd_sel_t              operand_b_fw_mux_sel_o,
  // event counters
  output logic [ctrl_pkg::PERF_CNT_W-1:0] jump_cnt_o,
  output logic [ctrl_pkg::PERF_CNT_W-1:0] jr_stall_cnt_o,
  output logic [ctrl_pkg::PERF_CNT_W-1:0] ld_stall_cnt_o
);

  // FSM holds a jump redirect on jr_stall_o, hazard unit reads is_decoding_o
  pipe_ctrl_fsm pipe_ctrl_fsm_i (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .fetch_enable_i         (fetch_enable_i),
    .instr_valid_i          (instr_valid_i),
    .branch_taken_ex_i      (branch_taken_ex_i),
    .jump_in_dec_i          (jump_in_dec_i),
    .eret_insn_i            (eret_insn_i),
    .pipe_flush_i           (pipe_flush_i),
    .exc_req_i              (exc_req_i),
    .ext_req_i              (ext_req_i),
    .id_ready_i             (id_ready_i),
    .ex_valid_i             (ex_valid_i),
    .jr_stall_i             (jr_stall_o),
    .instr_req_o            (instr_req_o),
    .ctrl_busy_o            (ctrl_busy_o),
    .is_decoding_o          (is_decoding_o),
    .pc_set_o               (pc_set_o),
    .pc_mux_o               (pc_mux_o),
    .exc_ack_o              (exc_ack_o),
    .exc_save_if_o          (exc_save_if_o),
    .exc_save_id_o          (exc_save_id_o),
    .exc_save_takenbranch_o (exc_save_takenbranch_o),
    .exc_restore_id_o       (exc_restore_id_o),
    .halt_if_o              (halt_if_o),
    .halt_id_o              (halt_id_o)
  );

  hazard_unit hazard_unit_i (
    .is_decoding_i        (is_decoding_o),
    .illegal_insn_i       (illegal_insn_i),
    .jump_in_dec_i        (jump_in_dec_i),
    .data_req_ex_i        (data_req_ex_i),
    .regfile_we_ex_i      (regfile_we_ex_i),
    .regfile_we_wb_i      (regfile_we_wb_i),
    .regfile_alu_we_fw_i  (regfile_alu_we_fw_i),
    .reg_d_ex_is_reg_a_i  (reg_d_ex_is_reg_a_i),
    .reg_d_ex_is_reg_b_i  (reg_d_ex_is_reg_b_i),
    .reg_d_wb_is_reg_a_i  (reg_d_wb_is_reg_a_i),
    .reg_d_alu_is_reg_a_i (reg_d_alu_is_reg_a_i),
    .load_stall_o         (load_stall_o),
    .jr_stall_o           (jr_stall_o),
    .deassert_we_o        (deassert_we_o)
  );

  operand_fwd_unit operand_fwd_unit_i (
    .regfile_we_wb_i        (regfile_we_wb_i),
    .regfile_alu_we_fw_i    (regfile_alu_we_fw_i),
    .reg_d_wb_is_reg_a_i    (reg_d_wb_is_reg_a_i),
    .reg_d_wb_is_reg_b_i    (reg_d_wb_is_reg_b_i),
    .reg_d_alu_is_reg_a_i   (reg_d_alu_is_reg_a_i),
    .reg_d_alu_is_reg_b_i   (reg_d_alu_is_reg_b_i),
    .operand_a_fw_mux_sel_o (operand_a_fw_mux_sel_o),
    .operand_b_fw_mux_sel_o (operand_b_fw_mux_sel_o)
  );

  perf_counters perf_counters_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .jump_in_id_i   (jump_in_id_i),
    .jr_stall_i     (jr_stall_o),
    .load_stall_i   (load_stall_o),
    .jump_cnt_o     (jump_cnt_o),
    .jr_stall_cnt_o (jr_stall_cnt_o),
    .ld_stall_cnt_o (ld_stall_cnt_o)
  );

endmodule

//--- test/core_controller_checker.sv
/*
 * Core controller checker
 * concurrent assertions on the redirect and exception outputs
 */
module core_controller_checker (
  input logic              clk,
  input logic              rst_n,
  input logic              id_ready_i,
  input logic              instr_req_o,
  input logic              pc_set_o,
  input ctrl_pkg::pc_mux_t pc_mux_o,
  input logic              exc_ack_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import ctrl_pkg::*;

  // a redirect always comes with a fetch request
  assert property (@(posedge clk) disable iff (!rst_n) pc_set_o |-> instr_req_o)
    else $error("pc_set_o without instr_req_o");

  // an exception ack loads the exception vector
  assert property (@(posedge clk) disable iff (!rst_n)
                   exc_ack_o |-> (pc_set_o && pc_mux_o == PC_EXCEPTION))
    else $error("exc_ack_o without an exception redirect");

  // jump_done keeps a stalled jump from redirecting twice
  assert property (@(posedge clk) disable iff (!rst_n)
                   (pc_set_o && pc_mux_o == PC_JUMP && !id_ready_i)
                   |=> (id_ready_i || !(pc_set_o && pc_mux_o == PC_JUMP)))
    else $error("jump redirect repeated while ID was stalled");

endmodule

bind core_controller core_controller_checker checker_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .id_ready_i  (id_ready_i),
  .instr_req_o (instr_req_o),
  .pc_set_o    (pc_set_o),
  .pc_mux_o    (pc_mux_o),
  .exc_ack_o   (exc_ack_o)
);

//--- test/core_controller_tb.sv
/*
 * Core controller testbench
 * applies a table of stimulus and expected outputs in a loop, then
 * compares the event counters with the counts taken from the table
 */
module core_controller_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import ctrl_pkg::*;

  localparam int RESET_CYCLES = 4;
  localparam int RANDOM_ROWS  = 40;

  // F V I E P B | dec id | X T R W | D WE WW AW | ea eb wa wb aa ab
  typedef struct packed {
    logic       fetch_en, instr_valid, illegal, eret, flush, br_taken;
    logic [1:0] jmp_dec, jmp_id;
    logic       exc_req, ext_req, id_ready, ex_valid;
    logic       data_req, we_ex, we_wb, alu_we;
    logic       ex_a, ex_b, wb_a, wb_b, alu_a, alu_b;
  } stim_t;

  // IQ BZ DC PS | mux | AK SI SD ST RI HI HD | DW LS JS | fwa fwb
  typedef struct packed {
    logic       instr_req, busy, decoding, pc_set;
    logic [2:0] pc_mux;
    logic       exc_ack, save_if, save_id, save_tb, restore_id, halt_if, halt_id;
    logic       deassert_we, load_stall, jr_stall;
    logic [1:0] fwa, fwb;
  } resp_t;

  logic clk, rst_n;
  logic fetch_enable_i, instr_valid_i, illegal_insn_i, eret_insn_i, pipe_flush_i;
  logic branch_taken_ex_i, exc_req_i, ext_req_i, id_ready_i, ex_valid_i, data_req_ex_i;
  logic regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i;
  logic reg_d_ex_is_reg_a_i, reg_d_ex_is_reg_b_i, reg_d_wb_is_reg_a_i;
  logic reg_d_wb_is_reg_b_i, reg_d_alu_is_reg_a_i, reg_d_alu_is_reg_b_i;
  jump_kind_t jump_in_dec_i, jump_in_id_i;
  logic instr_req_o, ctrl_busy_o, is_decoding_o, pc_set_o, exc_ack_o;
  logic exc_save_if_o, exc_save_id_o, exc_save_takenbranch_o, exc_restore_id_o;
  logic halt_if_o, halt_id_o, deassert_we_o, load_stall_o, jr_stall_o;
  pc_mux_t  pc_mux_o;
  fwd_sel_t operand_a_fw_mux_sel_o, operand_b_fw_mux_sel_o;
  logic [PERF_CNT_W-1:0] jump_cnt_o, jr_stall_cnt_o, ld_stall_cnt_o;

  stim_t stim_q[$];
  resp_t exp_q[$];
  resp_t mask_q[$];
  int    cycles     = 0;
  int    max_cycles = 1000;

  core_controller dut_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // run limit
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles > max_cycles)
    begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("Test failures found");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check_val(input string msg, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("FAILED at %0t: %s (got %h, expected %h)", $time, msg, got, exp);
      $display("Test failures found");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic apply(input stim_t s);
    fetch_enable_i       = s.fetch_en;
    instr_valid_i        = s.instr_valid;
    illegal_insn_i       = s.illegal;
    eret_insn_i          = s.eret;
    pipe_flush_i         = s.flush;
    branch_taken_ex_i    = s.br_taken;
    jump_in_dec_i        = jump_kind_t'(s.jmp_dec);
    jump_in_id_i         = jump_kind_t'(s.jmp_id);
    exc_req_i            = s.exc_req;
    ext_req_i            = s.ext_req;
    id_ready_i           = s.id_ready;
    ex_valid_i           = s.ex_valid;
    data_req_ex_i        = s.data_req;
    regfile_we_ex_i      = s.we_ex;
    regfile_we_wb_i      = s.we_wb;
    regfile_alu_we_fw_i  = s.alu_we;
    reg_d_ex_is_reg_a_i  = s.ex_a;
    reg_d_ex_is_reg_b_i  = s.ex_b;
    reg_d_wb_is_reg_a_i  = s.wb_a;
    reg_d_wb_is_reg_b_i  = s.wb_b;
    reg_d_alu_is_reg_a_i = s.alu_a;
    reg_d_alu_is_reg_b_i = s.alu_b;
  endtask

  function automatic resp_t read_outputs();
    return {instr_req_o, ctrl_busy_o, is_decoding_o, pc_set_o, pc_mux_o, exc_ack_o,
            exc_save_if_o, exc_save_id_o, exc_save_takenbranch_o, exc_restore_id_o,
            halt_if_o, halt_id_o, deassert_we_o, load_stall_o, jr_stall_o,
            operand_a_fw_mux_sel_o, operand_b_fw_mux_sel_o};
  endfunction

  // hazard and forwarding rules for a decode cycle with no branch in EX
  function automatic resp_t expect_fwd_hazard(input stim_t s);
    resp_t e;
    e            = '0;
    e.decoding   = s.instr_valid;
    e.load_stall = s.data_req & s.we_ex & (s.ex_a | s.ex_b);
    e.jr_stall   = (s.jmp_dec == BRANCH_JALR) &
                   ((s.we_wb & s.wb_a) | (s.we_ex & s.ex_a) | (s.alu_we & s.alu_a));
    e.deassert_we = ~e.decoding | s.illegal | e.load_stall | e.jr_stall;
    // ALU result is younger than WB
    e.fwa = (s.alu_we & s.alu_a) ? SEL_FW_EX : (s.we_wb & s.wb_a) ? SEL_FW_WB : SEL_REGFILE;
    e.fwb = (s.alu_we & s.alu_b) ? SEL_FW_EX : (s.we_wb & s.wb_b) ? SEL_FW_WB : SEL_REGFILE;
    return e;
  endfunction

  task automatic add_row(input stim_t s, input resp_t e, input resp_t m);
    stim_q.push_back(s);
    exp_q.push_back(e);
    mask_q.push_back(m);
  endtask

  task automatic load_table();
    logic [31:0] r;
    stim_t       s;
    // reset idle, then fetch enable and boot
    add_row(24'b000000_0000_0000_0000_000000, 21'b0000_000_0000000_100_0000, '1);
    add_row(24'b100000_0000_0000_0000_000000, 21'b0000_000_0000000_100_0000, '1);
    add_row(24'b100000_0000_0000_0000_000000, 21'b1101_000_0000000_100_0000, '1);
    // first fetch holds without id_ready
    add_row(24'b100000_0000_0000_0000_000000, 21'b1100_000_0000000_100_0000, '1);
    add_row(24'b100000_0000_0010_0000_000000, 21'b1100_000_0000000_100_0000, '1);
    add_row(24'b110000_0000_0010_0000_000000, 21'b1110_000_0000000_000_0000, '1);
    // JAL under back-pressure redirects once
    add_row(24'b110000_0101_0000_0000_000000, 21'b1111_010_0000000_000_0000, '1);
    add_row(24'b110000_0101_0000_0000_000000, 21'b1110_010_0000000_000_0000, '1);
    add_row(24'b110000_0101_0010_0000_000000, 21'b1110_010_0000000_000_0000, '1);
    // JALR waits on a pending WB write
    add_row(24'b110000_1010_0000_0010_001000, 21'b1110_010_0000000_101_1000, '1);
    // taken branch, then eret once
    add_row(24'b110001_0000_0010_0000_000000, 21'b1101_011_0000000_100_0000, '1);
    add_row(24'b110100_0000_0000_0000_000000, 21'b1111_101_0000100_000_0000, '1);
    add_row(24'b110100_0000_0010_0000_000000, 21'b1110_101_0000100_000_0000, '1);
    // exception in ID, interrupt with empty ID, interrupt on a taken branch
    add_row(24'b110000_0000_1010_0000_000000, 21'b1111_100_1010001_000_0000, '1);
    add_row(24'b100000_0000_0110_0000_000000, 21'b1101_100_1100001_100_0000, '1);
    add_row(24'b110001_0000_0110_0000_000000, 21'b1101_100_1001001_100_0000, '1);
    // flush with fetch on, FLUSH_EX waits for ex_valid
    add_row(24'b110010_0000_0010_0000_000000, 21'b1110_000_0000011_000_0000, '1);
    add_row(24'b100000_0000_0000_0000_000000, 21'b1100_000_0000011_100_0000, '1);
    add_row(24'b100000_0000_0000_0000_000000, 21'b1100_000_0000011_100_0000, '1);
    add_row(24'b100000_0000_0001_0000_000000, 21'b1100_000_0000011_100_0000, '1);
    add_row(24'b100000_0000_0000_0000_000000, 21'b1100_000_0000001_100_0000, '1);
    // flush with fetch off goes to sleep, exc_req wakes it
    add_row(24'b010010_0000_0010_0000_000000, 21'b1110_000_0000011_000_0000, '1);
    add_row(24'b000000_0000_0001_0000_000000, 21'b1100_000_0000011_100_0000, '1);
    add_row(24'b000000_0000_0000_0000_000000, 21'b1100_000_0000011_100_0000, '1);
    add_row(24'b000000_0000_0000_0000_000000, 21'b0000_000_0000011_100_0000, '1);
    add_row(24'b000000_0000_1000_0000_000000, 21'b0000_000_0000011_100_0000, '1);
    add_row(24'b000000_0000_0000_0000_000000, 21'b1100_000_0000000_100_0000, '1);
    add_row(24'b100000_0000_0010_0000_000000, 21'b1100_000_0000000_100_0000, '1);
    // random decode rows, only hazard and forwarding outputs are checked
    repeat (RANDOM_ROWS)
    begin
      r = $urandom;
      s = {1'b1, r[0], r[1], 3'b000, r[3:2], r[5:4], 4'b0010, r[9:6], r[15:10]};
      add_row(s, expect_fwd_hazard(s), 21'b0010_000_0000000_111_1111);
    end
  endtask

  initial
  begin
    resp_t                 m;
    logic [PERF_CNT_W-1:0] n_jump;
    logic [PERF_CNT_W-1:0] n_jr;
    logic [PERF_CNT_W-1:0] n_ld;
    void'($urandom(32'ha37ce854));
    rst_n  = 1'b0;
    n_jump = '0;
    n_jr   = '0;
    n_ld   = '0;
    apply('0);
    load_table();
    max_cycles = stim_q.size() + RESET_CYCLES + 20;

    repeat (RESET_CYCLES)
    begin
      @(negedge clk);
      #25;
      check_val("outputs in reset", 64'(read_outputs()), 64'(21'b0000_000_0000000_100_0000));
      check_val("counters in reset", 64'({jump_cnt_o, jr_stall_cnt_o, ld_stall_cnt_o}), 64'(0));
    end
    @(negedge clk);
    rst_n = 1'b1;

    foreach (stim_q[i])
    begin
      @(negedge clk);
      apply(stim_q[i]);
      #25;
      m = mask_q[i];
      check_val($sformatf("row %0d outputs", i), 64'(read_outputs() & m), 64'(exp_q[i] & m));
      if (stim_q[i].jmp_id == BRANCH_JAL || stim_q[i].jmp_id == BRANCH_JALR)
        n_jump = n_jump + PERF_CNT_W'(1);
      if (exp_q[i].jr_stall)
        n_jr = n_jr + PERF_CNT_W'(1);
      if (exp_q[i].load_stall)
        n_ld = n_ld + PERF_CNT_W'(1);
    end

    @(negedge clk);
    apply('0);
    check_val("jump counter", 64'(jump_cnt_o), 64'(n_jump));
    check_val("jump-register stall counter", 64'(jr_stall_cnt_o), 64'(n_jr));
    check_val("load stall counter", 64'(ld_stall_cnt_o), 64'(n_ld));
    $display("All tests passed!");
    $finish;
  end

endmodule

//--- compile.f
source/ctrl_pkg.sv
source/pipe_ctrl_fsm.sv
source/hazard_unit.sv
source/operand_fwd_unit.sv
source/perf_counters.sv
source/core_controller.sv
test/core_controller_checker.sv
test/core_controller_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := core_controller_tb
FLIST     := compile.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard source/*.sv) $(wildcard test/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
